//--- source/spi_bridge_pkg.sv
// ####################
// shared types and constants for the spi register bridge
// imported by the front end, fifo, register bank and testbench
// ####################
package spi_bridge_pkg;

	localparam int fifo_depth = 4; // also the initial credit count
	localparam int credit_w   = 3;
	localparam int ptr_w      = $clog2(fifo_depth);

	// register numbers as sent by the avr
	localparam logic [7:0] reg_kbd     = 8'h10;
	localparam logic [7:0] reg_mus_x   = 8'h20;
	localparam logic [7:0] reg_mus_y   = 8'h21;
	localparam logic [7:0] reg_mus_btn = 8'h22;
	localparam logic [7:0] reg_kj      = 8'h23;
	localparam logic [7:0] reg_rst     = 8'h30;
	localparam logic [7:0] reg_glu     = 8'h41; // read-back of gluclock address
	localparam logic [7:0] reg_com     = 8'h42; // read-back of com port address
	localparam logic [7:0] reg_cfg0    = 8'h50;

	// layout of the reset register byte
	typedef struct packed {
		logic [1:0] rsv_hi;
		logic [1:0] rom_page; // rom page selected after z80 reset
		logic [3:0] rsv_lo;
	} rst_fields_t;

	// reg_rst decodes fields, all other registers take the plain byte
	typedef union packed {
		logic [7:0]  raw;
		rst_fields_t rst;
	} reg_payload_u;

	// one completed spi data frame
	typedef struct packed {
		logic [7:0]   regnum;
		reg_payload_u payload;
	} reg_txn_t;

	typedef struct packed {
		logic [7:0] data;   // shared by all mouse and joystick registers
		logic       xstb;
		logic       ystb;
		logic       btnstb;
		logic       kjstb;
	} mouse_out_t;

endpackage

//--- source/spi_frontend.sv
`timescale 1ns/1ps
// ####################
// spi slave front end, turns each data frame into a fifo push
// push only while credits remain, otherwise pulse overrun
// ####################
module spi_frontend
	import spi_bridge_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       spics_n,
	input  logic       spick,
	input  logic       spido,
	output logic       spidi,
	input  logic [7:0] status_in,
	input  logic [7:0] gluclock_addr,
	input  logic [7:0] comport_addr,
	input  logic       credit_ret,
	output logic       push,
	output reg_txn_t   txn,
	output logic       overrun
);

	logic [1:0] cs_sync;
	logic [1:0] sck_sync;
	logic [1:0] sdo_sync;
	logic       cs_lvl;   // synchronized chip-select, high in register phase
	logic       sck_lvl;
	logic       sdo_lvl;  // aligned with sck_rise
	logic       cs_rise;
	logic       cs_fall;
	logic       sck_rise;

	logic [7:0] regnum;
	logic [7:0] data_sr;
	logic [7:0] shift_out;
	logic [7:0] rd_byte;
	logic       in_frame;
	logic       ret_q;
	logic [credit_w-1:0] credits;
	logic       frame_end;
	logic       do_push;

	// two sync flops then one registered edge stage
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cs_sync  <= 2'b11;
			sck_sync <= 2'b00;
			sdo_sync <= 2'b00;
			cs_lvl   <= 1'b1;
			sck_lvl  <= 1'b0;
			sdo_lvl  <= 1'b0;
			cs_rise  <= 1'b0;
			cs_fall  <= 1'b0;
			sck_rise <= 1'b0;
		end
		else
		begin
			cs_sync  <= {cs_sync[0], spics_n};
			sck_sync <= {sck_sync[0], spick};
			sdo_sync <= {sdo_sync[0], spido};
			cs_lvl   <= cs_sync[1];
			sck_lvl  <= sck_sync[1];
			sdo_lvl  <= sdo_sync[1];
			cs_rise  <= cs_sync[1] & ~cs_lvl;
			cs_fall  <= ~cs_sync[1] & cs_lvl;
			sck_rise <= sck_sync[1] & ~sck_lvl;
		end
	end

	always_comb
	begin
		case (regnum)
			reg_glu: rd_byte = gluclock_addr;
			reg_com: rd_byte = comport_addr;
			default: rd_byte = 8'hff;
		endcase
	end

	// register number and outgoing byte, both lsb first
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			regnum    <= '0;
			shift_out <= status_in; // idle is a register phase
		end
		else
		begin
			if (cs_rise)
				regnum <= '0;
			else if (cs_lvl && sck_rise)
				regnum <= {sdo_lvl, regnum[7:1]};

			if (cs_rise)
				shift_out <= status_in;
			else if (cs_fall)
				shift_out <= rd_byte;
			else if (sck_rise)
				shift_out <= {1'b0, shift_out[7:1]};
		end
	end

	assign spidi = shift_out[0];

	always_ff @(posedge fclk)
	begin
		if (!cs_lvl && sck_rise)
			data_sr <= {sdo_lvl, data_sr[7:1]};
		if (cs_rise)
		begin
			txn.regnum      <= regnum; // still the old number here
			txn.payload.raw <= data_sr;
		end
	end

	assign frame_end = cs_rise && in_frame;
	assign do_push   = frame_end && (credits != '0);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			push     <= 1'b0;
			overrun  <= 1'b0;
			in_frame <= 1'b0;
			ret_q    <= 1'b0;
			credits  <= credit_w'(fifo_depth);
		end
		else
		begin
			push    <= do_push;
			overrun <= frame_end && (credits == '0);
			ret_q   <= credit_ret;
			if (cs_fall)
				in_frame <= 1'b1;
			else if (cs_rise)
				in_frame <= 1'b0;
			case ({ret_q, do_push})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits; // none or both
			endcase
		end
	end

endmodule

//--- source/txn_fifo.sv
`timescale 1ns/1ps
// ####################
// small circular fifo between front end and register bank
// every pop hands one credit back to the front end
// ####################
module txn_fifo
	import spi_bridge_pkg::*;
(
	input  logic     fclk,
	input  logic     rst_n,
	input  logic     push,
	input  reg_txn_t txn_in,
	input  logic     pop,
	output reg_txn_t txn_out,
	output logic     not_empty,
	output logic     credit_ret
);

	reg_txn_t mem [fifo_depth];

	logic [ptr_w-1:0]    wr_ptr;
	logic [ptr_w-1:0]    rd_ptr;
	logic [credit_w-1:0] count;
	logic                do_pop;

	assign not_empty  = (count != '0);
	assign do_pop     = pop && not_empty;
	assign credit_ret = do_pop; // same cycle as the pop
	assign txn_out    = mem[rd_ptr];

	// no full check, credits keep a slot free
	always_ff @(posedge fclk)
	begin
		if (push)
			mem[wr_ptr] <= txn_in;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at fifo_depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/reg_bank.sv
`timescale 1ns/1ps
// ####################
// register bank, drains the fifo one transaction per cycle
// and turns each into strobes and held outputs
// ####################
module reg_bank
	import spi_bridge_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  reg_txn_t   txn,
	input  logic       not_empty,
	output logic       pop,
	output logic [7:0] kbd_out,
	output logic       kbd_stb,
	output mouse_out_t mouse,
	output logic       genrst,
	output logic [1:0] rstrom,
	output logic [7:0] config0
);

	logic       hit_kbd;
	logic       hit_mus_x;
	logic       hit_mus_y;
	logic       hit_mus_btn;
	logic       hit_kj;
	logic       hit_rst;
	logic       hit_cfg0;
	logic       hit_mouse;
	logic [7:0] mus_data;
	logic [3:0] mus_stb;  // x, y, btn, kj

	// never stalls
	assign pop = not_empty;

	assign hit_kbd     = pop && (txn.regnum == reg_kbd);
	assign hit_mus_x   = pop && (txn.regnum == reg_mus_x);
	assign hit_mus_y   = pop && (txn.regnum == reg_mus_y);
	assign hit_mus_btn = pop && (txn.regnum == reg_mus_btn);
	assign hit_kj      = pop && (txn.regnum == reg_kj);
	assign hit_rst     = pop && (txn.regnum == reg_rst);
	assign hit_cfg0    = pop && (txn.regnum == reg_cfg0);
	assign hit_mouse   = hit_mus_x || hit_mus_y || hit_mus_btn || hit_kj;

	// strobes and held config
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			kbd_stb <= 1'b0;
			mus_stb <= '0;
			genrst  <= 1'b0;
			rstrom  <= 2'b00;
			config0 <= '0;
		end
		else
		begin
			kbd_stb <= hit_kbd;
			mus_stb <= {hit_mus_x, hit_mus_y, hit_mus_btn, hit_kj};
			genrst  <= hit_rst; // one cycle pulse
			if (hit_rst)
				rstrom <= txn.payload.rst.rom_page;
			if (hit_cfg0)
				config0 <= txn.payload.raw;
		end
	end

	// data bytes only matter with their strobe
	always_ff @(posedge fclk)
	begin
		if (hit_kbd)
			kbd_out <= txn.payload.raw;
		if (hit_mouse)
			mus_data <= txn.payload.raw;
	end

	assign mouse.data   = mus_data;
	assign mouse.xstb   = mus_stb[3];
	assign mouse.ystb   = mus_stb[2];
	assign mouse.btnstb = mus_stb[1];
	assign mouse.kjstb  = mus_stb[0];

endmodule

//--- source/avr_spi_top.sv
`timescale 1ns/1ps
// ####################
// avr spi register bridge top, front end -> fifo -> register bank
// ####################
module avr_spi_top
	import spi_bridge_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       spics_n,  // avr spi pins
	input  logic       spick,
	input  logic       spido,
	output logic       spidi,
	input  logic [7:0] status_in,
	input  logic [7:0] gluclock_addr,
	input  logic [7:0] comport_addr,
	output logic       overrun,
	output logic [7:0] kbd_out,
	output logic       kbd_stb,
	output mouse_out_t mouse,
	output logic       genrst,  // z80 reset pulse
	output logic [1:0] rstrom,
	output logic [7:0] config0
);

	logic     push;
	reg_txn_t fe_txn;
	reg_txn_t head_txn;
	logic     pop;
	logic     not_empty;
	logic     credit_ret;

	spi_frontend u_frontend (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.spics_n       (spics_n),
		.spick         (spick),
		.spido         (spido),
		.spidi         (spidi),
		.status_in     (status_in),
		.gluclock_addr (gluclock_addr),
		.comport_addr  (comport_addr),
		.credit_ret    (credit_ret),
		.push          (push),
		.txn           (fe_txn),
		.overrun       (overrun)
	);

	txn_fifo u_fifo (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.push       (push),
		.txn_in     (fe_txn),
		.pop        (pop),
		.txn_out    (head_txn),
		.not_empty  (not_empty),
		.credit_ret (credit_ret)
	);

	reg_bank u_regs (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.txn       (head_txn),
		.not_empty (not_empty),
		.pop       (pop),
		.kbd_out   (kbd_out),
		.kbd_stb   (kbd_stb),
		.mouse     (mouse),
		.genrst    (genrst),
		.rstrom    (rstrom),
		.config0   (config0)
	);

endmodule

//--- test/spi_master.svh
// ####################
// bit-banged spi master for the bridge testbench
// included inside the testbench module, drives pins just after fclk edges
// ####################
`ifndef spi_master_svh
`define spi_master_svh

// wait n rising edges, then step past the edge
task automatic tick(input int n);
	repeat (n) @(posedge fclk);
	#(drive_dly);
endtask

// one bit, spick low for hb cycles then high for hb cycles
task automatic xfer_bit(input logic out_bit, input int hb, output logic in_bit);
	spido = out_bit;
	tick(hb);
	in_bit = spidi; // slave has shifted by now
	spick = 1'b1;
	tick(hb);
	spick = 1'b0;
endtask

// lsb first in both directions
task automatic xfer_byte(input logic [7:0] out_byte, input int hb, output logic [7:0] in_byte);
	int   i;
	logic b;
	for (i = 0; i < 8; i++)
	begin
		xfer_bit(out_byte[i], hb, b);
		in_byte[i] = b;
	end
endtask

// register number with cs high, then one data byte with cs low
task automatic spi_frame(input logic [7:0] regnum, input logic [7:0] data, input int hb,
	output logic [7:0] status_rd, output logic [7:0] data_rd);
	xfer_byte(regnum, hb, status_rd);
	spics_n = 1'b0;
	tick(cs_gap); // let the slave load the read byte
	xfer_byte(data, hb, data_rd);
	spics_n = 1'b1; // frame ends here, push follows
	tick(cs_gap);
endtask

`endif

//--- test/tb_avr_spi.sv
`timescale 1ns/1ps
// ####################
// testbench for the spi register bridge that runs a table of spi frames
// and checks strobes, held outputs, read data and overrun
// ####################
module tb_avr_spi
	import spi_bridge_pkg::*;
();

	localparam int clk_half     = 20;
	localparam int drive_dly    = 2;
	localparam int cs_gap       = 6;
	localparam int hb_norm      = 4;
	localparam int hb_fast      = 2; // burst frames
	localparam int cfg_wait     = 4;
	localparam int quiet_wait   = 8;
	localparam int strobe_window = 24;
	localparam int n_rows       = 19;
	localparam int timeout_cycles = n_rows * 200 + 500;
	localparam logic [7:0] status_val = 8'h5a;
	localparam logic [7:0] glu_val    = 8'h3c;
	localparam logic [7:0] com_val    = 8'hc6;

	typedef enum logic [2:0] {
		k_none, k_kbd, k_mus_x, k_mus_y, k_mus_btn, k_kj, k_rst, k_cfg
	} kind_e;

	typedef struct packed {
		logic [7:0] regnum;
		logic [7:0] data;
		logic [7:0] rd_exp; // expected byte on spidi in the data phase
		kind_e      kind;
		logic       fast;
	} row_t;

	typedef struct packed {
		kind_e       kind;
		logic [7:0]  kbd;
		mouse_out_t  mus;
		rst_fields_t rst;
	} strobe_ev_t;

	logic       fclk = 1'b0;
	logic       rst_n;
	logic       spics_n;
	logic       spick;
	logic       spido;
	logic       spidi;
	logic [7:0] status_in;
	logic [7:0] gluclock_addr;
	logic [7:0] comport_addr;
	logic       overrun;
	logic [7:0] kbd_out;
	logic       kbd_stb;
	mouse_out_t mouse;
	logic       genrst;
	logic [1:0] rstrom;
	logic [7:0] config0;

	row_t        table_rows [n_rows];
	int          n_built    = 0;
	logic [31:0] lcg_state  = 32'hbe68;
	strobe_ev_t  ev_q [$];
	strobe_ev_t  mon_ev;
	logic [5:0]  stb_vec;
	int          pending [$];
	int          strobe_cnt = 0;
	int          push_cnt   = 0;
	int          ovr_cnt    = 0;
	int          cycle_cnt  = 0;
	logic [7:0]  last_cfg   = 8'h00;

	avr_spi_top DUT (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.spics_n       (spics_n),
		.spick         (spick),
		.spido         (spido),
		.spidi         (spidi),
		.status_in     (status_in),
		.gluclock_addr (gluclock_addr),
		.comport_addr  (comport_addr),
		.overrun       (overrun),
		.kbd_out       (kbd_out),
		.kbd_stb       (kbd_stb),
		.mouse         (mouse),
		.genrst        (genrst),
		.rstrom        (rstrom),
		.config0       (config0)
	);

	`include "spi_master.svh"

	always #(clk_half) fclk = ~fclk;

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge fclk)
	begin
		cycle_cnt++;
		if (cycle_cnt > timeout_cycles)
		begin
			$display("timeout, the test did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	// collect every strobe and overrun pulse mid-cycle
	always @(negedge fclk)
	begin
		if (rst_n)
		begin
			if (overrun)
				ovr_cnt++;
			stb_vec = {kbd_stb, mouse.xstb, mouse.ystb, mouse.btnstb, mouse.kjstb, genrst};
			if ($countones(stb_vec) > 1)
			begin
				$display("more than one strobe fired in the same cycle at %0t", $time);
				abort_run();
			end
			else if (stb_vec != '0)
			begin
				mon_ev = '0;
				mon_ev.kbd = kbd_out;
				mon_ev.mus = mouse;
				mon_ev.rst.rom_page = rstrom;
				if (kbd_stb)
					mon_ev.kind = k_kbd;
				else if (mouse.xstb)
					mon_ev.kind = k_mus_x;
				else if (mouse.ystb)
					mon_ev.kind = k_mus_y;
				else if (mouse.btnstb)
					mon_ev.kind = k_mus_btn;
				else if (mouse.kjstb)
					mon_ev.kind = k_kj;
				else
					mon_ev.kind = k_rst;
				ev_q.push_back(mon_ev);
				strobe_cnt++;
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[23:16];
	endfunction

	function automatic logic is_strobe_kind(input kind_e k);
		return (k != k_none) && (k != k_cfg);
	endfunction

	// only the written register's strobe with the data as sent
	function automatic mouse_out_t mouse_expect(input kind_e k, input logic [7:0] data);
		mouse_out_t m;
		m = '0;
		m.data = data;
		m.xstb = (k == k_mus_x);
		m.ystb = (k == k_mus_y);
		m.btnstb = (k == k_mus_btn);
		m.kjstb = (k == k_kj);
		return m;
	endfunction

	task automatic add_row(input logic [7:0] regnum, input logic [7:0] data,
		input logic [7:0] rd_exp, input kind_e kind, input logic fast);
		table_rows[n_built] = {regnum, data, rd_exp, kind, fast};
		n_built++;
	endtask

	task automatic build_table();
		add_row(reg_kbd, 8'h1c, 8'hff, k_kbd, 1'b0);
		add_row(reg_mus_x, rand_byte(), 8'hff, k_mus_x, 1'b0);
		add_row(reg_mus_y, rand_byte(), 8'hff, k_mus_y, 1'b0);
		add_row(reg_mus_btn, rand_byte(), 8'hff, k_mus_btn, 1'b0);
		add_row(reg_kj, rand_byte(), 8'hff, k_kj, 1'b0);
		add_row(reg_rst, 8'h20, 8'hff, k_rst, 1'b0);   // rom page 2
		add_row(reg_cfg0, 8'h5a, 8'hff, k_cfg, 1'b0);
		add_row(reg_glu, 8'h00, glu_val, k_none, 1'b0);
		add_row(reg_com, 8'h81, com_val, k_none, 1'b0);
		add_row(reg_rst, 8'hd3, 8'hff, k_rst, 1'b0);   // rom page 1
		add_row(8'h77, 8'h99, 8'hff, k_none, 1'b0);    // unknown register
		add_row(reg_cfg0, 8'ha7, 8'hff, k_cfg, 1'b0);
		add_row(reg_kbd, 8'he5, 8'hff, k_kbd, 1'b0);
		// back to back burst
		add_row(reg_mus_x, rand_byte(), 8'hff, k_mus_x, 1'b1);
		add_row(reg_kbd, 8'h42, 8'hff, k_kbd, 1'b1);
		add_row(reg_mus_y, rand_byte(), 8'hff, k_mus_y, 1'b1);
		add_row(reg_rst, 8'h30, 8'hff, k_rst, 1'b1);
		add_row(reg_mus_btn, rand_byte(), 8'hff, k_mus_btn, 1'b1);
		add_row(reg_kj, rand_byte(), 8'hff, k_kj, 1'b1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (exp !== got)
		begin
			$display("Fail at %0t: %s expected %02h got %02h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_mouse(input string name, input mouse_out_t exp, input mouse_out_t got);
		if (exp !== got)
		begin
			$display("Fail at %0t: %s expected %03h got %03h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_rst(input string name, input rst_fields_t exp, input rst_fields_t got);
		if (exp !== got)
		begin
			$display("Fail at %0t: %s expected %02h got %02h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic take_strobe(input int idx, output strobe_ev_t ev);
		int waited;
		waited = 0;
		while (ev_q.size() == 0 && waited < strobe_window)
		begin
			tick(1);
			waited++;
		end
		if (ev_q.size() == 0)
		begin
			$display("no strobe appeared for table row %0d within %0d cycles", idx, strobe_window);
			abort_run();
		end
		else
			ev = ev_q.pop_front();
	endtask

	// check the results of all frames sent so far in order
	task automatic check_pending();
		int          idx;
		row_t        r;
		strobe_ev_t  ev;
		rst_fields_t exp_rst;
		while (pending.size() > 0)
		begin
			idx = pending.pop_front();
			r = table_rows[idx];
			if (r.kind == k_cfg)
			begin
				tick(cfg_wait);
				check_byte("config0", r.data, config0);
				last_cfg = r.data;
			end
			else if (is_strobe_kind(r.kind))
			begin
				take_strobe(idx, ev);
				check_byte("strobe kind", 8'(r.kind), 8'(ev.kind));
				case (r.kind)
					k_kbd: check_byte("kbd_out", r.data, ev.kbd);
					k_rst:
					begin
						exp_rst = '0;
						exp_rst.rom_page = r.data[5:4];
						check_rst("rstrom", exp_rst, ev.rst);
					end
					default: check_mouse("mouse", mouse_expect(r.kind, r.data), ev.mus);
				endcase
			end
		end
		tick(quiet_wait);
		if (ev_q.size() != 0)
		begin
			$display("an unexpected strobe fired at %0t", $time);
			abort_run();
		end
		else
			check_byte("config0", last_cfg, config0); // held since the last cfg write
	endtask

	initial
	begin
		int         i;
		int         hb;
		int         ovr_before;
		logic       exp_ovr;
		logic       flush;
		row_t       r;
		logic [7:0] status_rd;
		logic [7:0] data_rd;
		rst_n = 1'b0;
		spics_n = 1'b1;
		spick = 1'b0;
		spido = 1'b0;
		status_in = status_val;
		gluclock_addr = glu_val;
		comport_addr = com_val;
		build_table();
		repeat (3) @(posedge fclk);
		#(drive_dly);
		rst_n = 1'b1;
		tick(2);
		for (i = 0; i < n_rows; i++)
		begin
			r = table_rows[i];
			hb = r.fast ? hb_fast : hb_norm;
			exp_ovr = ((push_cnt - strobe_cnt) == fifo_depth); // frame dropped when the fifo is full
			ovr_before = ovr_cnt;
			spi_frame(r.regnum, r.data, hb, status_rd, data_rd);
			check_byte("spidi status", status_val, status_rd);
			check_byte("spidi data", r.rd_exp, data_rd);
			check_byte("overrun", 8'(exp_ovr), 8'(ovr_cnt - ovr_before));
			if (!exp_ovr)
			begin
				pending.push_back(i);
				if (is_strobe_kind(r.kind))
					push_cnt++;
			end
			flush = !r.fast || (i == n_rows - 1);
			if (!flush)
				flush = !table_rows[i + 1].fast;
			if (flush)
				check_pending();
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- tb.f
+incdir+test
source/spi_bridge_pkg.sv
source/spi_frontend.sv
source/txn_fifo.sv
source/reg_bank.sv
source/avr_spi_top.sv
test/tb_avr_spi.sv

//--- Bender.yml
package:
  name: avr_spi_bridge

sources:
  - source/spi_bridge_pkg.sv
  - source/spi_frontend.sv
  - source/txn_fifo.sv
  - source/reg_bank.sv
  - source/avr_spi_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_avr_spi.sv
